// ==== source/des_pkg.sv ====
package des_pkg;

        localparam int block_w = 64;
        localparam int half_w = 32;
        localparam int key_w = 64;
        localparam int cd_w = 56; // Key width once PC1 has dropped the parity bits
        localparam int subkey_w = 48;
        localparam int num_rounds = 16;
        localparam int num_sboxes = 8;
        localparam int wb_aw = 3;
        localparam int wb_dw = 32;

        typedef logic [3:0] round_t;

        // Each entry is the source bit index, listed from the output MSB downwards
        localparam int ip_table [block_w] = '{
                 6, 14, 22, 30, 38, 46, 54, 62,  4, 12, 20, 28, 36, 44, 52, 60,
                 2, 10, 18, 26, 34, 42, 50, 58,  0,  8, 16, 24, 32, 40, 48, 56,
                 7, 15, 23, 31, 39, 47, 55, 63,  5, 13, 21, 29, 37, 45, 53, 61,
                 3, 11, 19, 27, 35, 43, 51, 59,  1,  9, 17, 25, 33, 41, 49, 57};

        localparam int fp_table [block_w] = '{
                24, 56, 16, 48,  8, 40,  0, 32, 25, 57, 17, 49,  9, 41,  1, 33,
                26, 58, 18, 50, 10, 42,  2, 34, 27, 59, 19, 51, 11, 43,  3, 35,
                28, 60, 20, 52, 12, 44,  4, 36, 29, 61, 21, 53, 13, 45,  5, 37,
                30, 62, 22, 54, 14, 46,  6, 38, 31, 63, 23, 55, 15, 47,  7, 39};

        localparam int e_table [subkey_w] = '{
                 0, 31, 30, 29, 28, 27, 28, 27, 26, 25, 24, 23, 24, 23, 22, 21,
                20, 19, 20, 19, 18, 17, 16, 15, 16, 15, 14, 13, 12, 11, 12, 11,
                10,  9,  8,  7,  8,  7,  6,  5,  4,  3,  4,  3,  2,  1,  0, 31};

        localparam int p_table [half_w] = '{
                16, 25, 12, 11,  3, 20,  4, 15, 31, 17,  9,  6, 27, 14,  1, 22,
                30, 24,  8, 18,  0,  5, 29, 23, 13, 19,  2, 26, 10, 21, 28,  7};

        localparam int pc1_table [cd_w] = '{
                 7, 15, 23, 31, 39, 47, 55, 63,  6, 14, 22, 30, 38, 46,
                54, 62,  5, 13, 21, 29, 37, 45, 53, 61,  4, 12, 20, 28,
                 1,  9, 17, 25, 33, 41, 49, 57,  2, 10, 18, 26, 34, 42,
                50, 58,  3, 11, 19, 27, 35, 43, 51, 59, 36, 44, 52, 60};

        localparam int pc2_table [subkey_w] = '{
                42, 39, 45, 32, 55, 51, 53, 28, 41, 50, 35, 46, 33, 37, 44, 52,
                30, 48, 40, 49, 29, 36, 43, 54, 15,  4, 25, 19,  9,  1, 26, 16,
                 5, 11, 23,  8, 12,  7, 17,  0, 22,  3, 10, 14,  6, 20, 27, 24};

        localparam int shift_table [num_rounds] = '{
                1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

        // Indexed straight by the 6-bit group, so row and column are already folded in
        localparam int sbox_table [num_sboxes][64] = '{
                '{14,  0,  4, 15, 13,  7,  1,  4,  2, 14, 15,  2, 11, 13,  8,  1,
                   3, 10, 10,  6,  6, 12, 12, 11,  5,  9,  9,  5,  0,  3,  7,  8,
                   4, 15,  1, 12, 14,  8,  8,  2, 13,  4,  6,  9,  2,  1, 11,  7,
                  15,  5, 12, 11,  9,  3,  7, 14,  3, 10, 10,  0,  5,  6,  0, 13},
                '{15,  3,  1, 13,  8,  4, 14,  7,  6, 15, 11,  2,  3,  8,  4, 14,
                   9, 12,  7,  0,  2,  1, 13, 10, 12,  6,  0,  9,  5, 11, 10,  5,
                   0, 13, 14,  8,  7, 10, 11,  1, 10,  3,  4, 15, 13,  4,  1,  2,
                   5, 11,  8,  6, 12,  7,  6, 12,  9,  0,  3,  5,  2, 14, 15,  9},
                '{10, 13,  0,  7,  9,  0, 14,  9,  6,  3,  3,  4, 15,  6,  5, 10,
                   1,  2, 13,  8, 12,  5,  7, 14, 11, 12,  4, 11,  2, 15,  8,  1,
                  13,  1,  6, 10,  4, 13,  9,  0,  8,  6, 15,  9,  3,  8,  0,  7,
                  11,  4,  1, 15,  2, 14, 12,  3,  5, 11, 10,  5, 14,  2,  7, 12},
                '{ 7, 13, 13,  8, 14, 11,  3,  5,  0,  6,  6, 15,  9,  0, 10,  3,
                   1,  4,  2,  7,  8,  2,  5, 12, 11,  1, 12, 10,  4, 14, 15,  9,
                  10,  3,  6, 15,  9,  0,  0,  6, 12, 10, 11,  1,  7, 13, 13,  8,
                  15,  9,  1,  4,  3,  5, 14, 11,  5, 12,  2,  7,  8,  2,  4, 14},
                '{ 2, 14, 12, 11,  4,  2,  1, 12,  7,  4, 10,  7, 11, 13,  6,  1,
                   8,  5,  5,  0,  3, 15, 15, 10, 13,  3,  0,  9, 14,  8,  9,  6,
                   4, 11,  2,  8,  1, 12, 11,  7, 10,  1, 13, 14,  7,  2,  8, 13,
                  15,  6,  9, 15, 12,  0,  5,  9,  6, 10,  3,  4,  0,  5, 14,  3},
                '{12, 10,  1, 15, 10,  4, 15,  2,  9,  7,  2, 12,  6,  9,  8,  5,
                   0,  6, 13,  1,  3, 13,  4, 14, 14,  0,  7, 11,  5,  3, 11,  8,
                   9,  4, 14,  3, 15,  2,  5, 12,  2,  9,  8,  5, 12, 15,  3, 10,
                   7, 11,  0, 14,  4,  1, 10,  7,  1,  6, 13,  0, 11,  8,  6, 13},
                '{ 4, 13, 11,  0,  2, 11, 14,  7, 15,  4,  0,  9,  8,  1, 13, 10,
                   3, 14, 12,  3,  9,  5,  7, 12,  5,  2, 10, 15,  6,  8,  1,  6,
                   1,  6,  4, 11, 11, 13, 13,  8, 12,  1,  3,  4,  7, 10, 14,  7,
                  10,  9, 15,  5,  6,  0,  8, 15,  0, 14,  5,  2,  9,  3,  2, 12},
                '{13,  1,  2, 15,  8, 13,  4,  8,  6, 10, 15,  3, 11,  7,  1,  4,
                  10, 12,  9,  5,  3,  6, 14, 11,  5,  0,  0, 14, 12,  9,  7,  2,
                   7,  2, 11,  1,  4, 14,  1,  7,  9,  4, 12, 10, 14,  8,  2, 13,
                   0, 15,  6, 12, 10,  9, 13,  0, 15,  3,  3,  5,  5,  6,  8, 11}};

        typedef struct packed {
                logic cyc;
                logic stb;
                logic we;
                logic [wb_aw-1:0] addr;
                logic [wb_dw-1:0] wdata;
        } wb_req_t;

        typedef struct packed {
                logic ack;
                logic [wb_dw-1:0] rdata;
        } wb_rsp_t;

        typedef struct packed {
                logic [key_w-1:0] key;
                logic [block_w-1:0] text;
        } des_req_t;

        localparam logic [wb_aw-1:0] addr_key_hi = 3'd0;
        localparam logic [wb_aw-1:0] addr_key_lo = 3'd1;
        localparam logic [wb_aw-1:0] addr_text_hi = 3'd2;
        localparam logic [wb_aw-1:0] addr_text_lo = 3'd3;
        localparam logic [wb_aw-1:0] addr_ctrl = 3'd4;
        localparam logic [wb_aw-1:0] addr_res_hi = 3'd5;
        localparam logic [wb_aw-1:0] addr_res_lo = 3'd6;

        function automatic logic [block_w-1:0] ip_perm(input logic [block_w-1:0] x);
                for (int i = 0; i < block_w; i++)
                        ip_perm[block_w-1-i] = x[ip_table[i]];
        endfunction

        function automatic logic [block_w-1:0] fp_perm(input logic [block_w-1:0] x);
                for (int i = 0; i < block_w; i++)
                        fp_perm[block_w-1-i] = x[fp_table[i]];
        endfunction

        function automatic logic [subkey_w-1:0] e_perm(input logic [half_w-1:0] x);
                for (int i = 0; i < subkey_w; i++)
                        e_perm[subkey_w-1-i] = x[e_table[i]];
        endfunction

        function automatic logic [half_w-1:0] p_perm(input logic [half_w-1:0] x);
                for (int i = 0; i < half_w; i++)
                        p_perm[half_w-1-i] = x[p_table[i]];
        endfunction

        function automatic logic [cd_w-1:0] pc1_perm(input logic [key_w-1:0] x);
                for (int i = 0; i < cd_w; i++)
                        pc1_perm[cd_w-1-i] = x[pc1_table[i]];
        endfunction

        function automatic logic [subkey_w-1:0] pc2_perm(input logic [cd_w-1:0] x);
                for (int i = 0; i < subkey_w; i++)
                        pc2_perm[subkey_w-1-i] = x[pc2_table[i]];
        endfunction

endpackage

// ==== source/des_key_schedule.sv ====
`timescale 1ns/100ps

module des_key_schedule (
        input  logic clk,
        input  logic arst_n,
        input  logic load,
        input  logic [des_pkg::key_w-1:0] key,
        input  des_pkg::round_t round,
        output logic [des_pkg::subkey_w-1:0] subkey
);
        import des_pkg::*;

        logic [cd_w/2-1:0] c_q;
        logic [cd_w/2-1:0] d_q;
        logic [cd_w/2-1:0] c_rot;
        logic [cd_w/2-1:0] d_rot;
        int shift;

        // The subkey of this round comes from the halves after their rotation
        always_comb begin
                shift = shift_table[round];
                c_rot = (c_q << shift) | (c_q >> (cd_w / 2 - shift));
                d_rot = (d_q << shift) | (d_q >> (cd_w / 2 - shift));
                subkey = pc2_perm({c_rot, d_rot});
        end

        // While idle the halves keep turning, the next load overwrites them anyway
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        c_q <= '0;
                        d_q <= '0;
                end else if (load) begin
                        {c_q, d_q} <= pc1_perm(key); // C takes the upper 28 bits
                end else begin
                        c_q <= c_rot;
                        d_q <= d_rot;
                end
        end

endmodule

// ==== source/des_feistel.sv ====
`timescale 1ns/100ps

module des_feistel (
        input  logic [des_pkg::half_w-1:0] r_half,
        input  logic [des_pkg::subkey_w-1:0] subkey,
        output logic [des_pkg::half_w-1:0] f_out
);
        import des_pkg::*;

        logic [subkey_w-1:0] mixed;
        logic [half_w-1:0] s_out;

        always_comb begin
                mixed = e_perm(r_half) ^ subkey;

                // S1 takes the top six bits and fills the top nibble
                for (int i = 0; i < num_sboxes; i++)
                        s_out[half_w-1-4*i -: 4] = 4'(sbox_table[i][mixed[subkey_w-1-6*i -: 6]]);

                f_out = p_perm(s_out);
        end

endmodule

// ==== source/des_core.sv ====
`timescale 1ns/100ps

module des_core (
        input  logic clk,
        input  logic arst_n,
        input  logic start,
        input  des_pkg::des_req_t req,
        output logic busy,
        output logic done,
        output logic [des_pkg::block_w-1:0] result
);
        import des_pkg::*;

        logic [half_w-1:0] l_half;
        logic [half_w-1:0] r_half;
        logic [half_w-1:0] f_out;
        logic [subkey_w-1:0] subkey;
        round_t round;

        // The key schedule picks up PC1 of the key on the same edge as the text
        des_key_schedule ks0 (
                .clk(clk),
                .arst_n(arst_n),
                .load(start),
                .key(req.key),
                .round(round),
                .subkey(subkey)
        );

        des_feistel feistel0 (
                .r_half(r_half),
                .subkey(subkey),
                .f_out(f_out)
        );

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        l_half <= '0;
                        r_half <= '0;
                        round <= '0;
                        busy <= 1'b0;
                        done <= 1'b0;
                        result <= '0;
                end else begin
                        done <= 1'b0;
                        if (start) begin
                                {l_half, r_half} <= ip_perm(req.text);
                                round <= '0;
                                busy <= 1'b1;
                        end else if (busy) begin
                                l_half <= r_half;
                                r_half <= l_half ^ f_out;
                                round <= round + 1'b1;
                                if (round == round_t'(num_rounds - 1)) begin
                                        // Last round swaps back, so R16 goes in front of L16
                                        result <= fp_perm({l_half ^ f_out, r_half});
                                        busy <= 1'b0;
                                        done <= 1'b1;
                                end
                        end
                end
        end

endmodule

// ==== source/des_wb_regs.sv ====
`timescale 1ns/100ps

module des_wb_regs (
        input  logic clk,
        input  logic arst_n,
        input  des_pkg::wb_req_t wb_req,
        output des_pkg::wb_rsp_t wb_rsp,
        input  logic busy,
        input  logic [des_pkg::block_w-1:0] result,
        input  logic done,
        output logic start,
        output des_pkg::des_req_t req
);
        import des_pkg::*;

        logic [key_w-1:0] key_q;
        logic [block_w-1:0] text_q;
        logic [block_w-1:0] res_q;
        logic access;
        logic [wb_dw-1:0] rdata;

        // Ack is high for one cycle only, so a held stb is not taken twice
        assign access = wb_req.cyc && wb_req.stb && !wb_rsp.ack;

        assign req = '{key: key_q, text: text_q};

        always_comb begin
                case (wb_req.addr)
                        addr_key_hi: rdata = key_q[key_w-1 -: wb_dw];
                        addr_key_lo: rdata = key_q[wb_dw-1:0];
                        addr_text_hi: rdata = text_q[block_w-1 -: wb_dw];
                        addr_text_lo: rdata = text_q[wb_dw-1:0];
                        addr_ctrl: rdata = wb_dw'(busy); // Status is busy in bit 0
                        addr_res_hi: rdata = res_q[block_w-1 -: wb_dw];
                        addr_res_lo: rdata = res_q[wb_dw-1:0];
                        default: rdata = '0;
                endcase
        end

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        wb_rsp <= '0;
                        key_q <= '0;
                        text_q <= '0;
                        res_q <= '0;
                        start <= 1'b0;
                end else begin
                        wb_rsp.ack <= access;
                        start <= 1'b0;
                        if (access && !wb_req.we)
                                wb_rsp.rdata <= rdata;
                        if (access && wb_req.we) begin
                                case (wb_req.addr)
                                        addr_key_hi: key_q[key_w-1 -: wb_dw] <= wb_req.wdata;
                                        addr_key_lo: key_q[wb_dw-1:0] <= wb_req.wdata;
                                        addr_text_hi: text_q[block_w-1 -: wb_dw] <= wb_req.wdata;
                                        addr_text_lo: text_q[wb_dw-1:0] <= wb_req.wdata;
                                        // A start written during a run is dropped
                                        addr_ctrl: start <= wb_req.wdata[0] && !busy;
                                        default: ;
                                endcase
                        end
                        if (done)
                                res_q <= result;
                end
        end

endmodule

// ==== source/des_top.sv ====
`timescale 1ns/100ps

module des_top (
        input  logic clk,
        input  logic arst_n,
        input  des_pkg::wb_req_t wb_req,
        output des_pkg::wb_rsp_t wb_rsp
);
        import des_pkg::*;

        logic start;
        logic busy;
        logic done;
        logic [block_w-1:0] result;
        des_req_t req;

        des_wb_regs regs0 (
                .clk(clk),
                .arst_n(arst_n),
                .wb_req(wb_req),
                .wb_rsp(wb_rsp),
                .busy(busy),
                .result(result),
                .done(done),
                .start(start),
                .req(req)
        );

        des_core core0 (
                .clk(clk),
                .arst_n(arst_n),
                .start(start),
                .req(req),
                .busy(busy),
                .done(done),
                .result(result)
        );

endmodule

// ==== verification/des_props.sv ====
`timescale 1ns/100ps

module des_props (
        input logic clk,
        input logic arst_n,
        input logic cyc,
        input logic stb,
        input logic ack,
        input logic start,
        input logic busy,
        input logic done
);

        ack_after_request: assert property (@(posedge clk) disable iff (!arst_n)
                $rose(ack) |-> $past(cyc && stb))
                else $error("ack rose without cyc and stb on the previous edge");

        ack_single_cycle: assert property (@(posedge clk) disable iff (!arst_n)
                ack |=> !ack)
                else $error("ack stayed high for two cycles");

        // The core only sees start while it is idle
        start_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
                start |-> !busy)
                else $error("start issued while the core was busy");

        done_ends_run: assert property (@(posedge clk) disable iff (!arst_n)
                done |-> !busy && $past(busy))
                else $error("done pulsed outside the end of a busy period");

endmodule

// The register block also carries busy and done of the core
bind des_wb_regs des_props props0 (
        .clk(clk),
        .arst_n(arst_n),
        .cyc(wb_req.cyc),
        .stb(wb_req.stb),
        .ack(wb_rsp.ack),
        .start(start),
        .busy(busy),
        .done(done)
);

// ==== verification/des_tb.sv ====
`timescale 1ns/100ps

module des_tb;
        import des_pkg::*;

        logic clk;
        logic arst_n;
        wb_req_t wb_req;
        wb_rsp_t wb_rsp;

        integer seed;
        int pass_count;
        int fail_count;
        int test_errors;

        string names [$];
        logic [63:0] keys [$];
        logic [63:0] texts [$];
        logic [63:0] ciphers [$];

        des_top dut0 (
                .clk(clk),
                .arst_n(arst_n),
                .wb_req(wb_req),
                .wb_rsp(wb_rsp)
        );

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        // Every task returns 2 ns after a rising edge, where inputs are driven
        task automatic idle_cycles(input int n);
                repeat (n) begin
                        @(posedge clk);
                        #2;
                end
        endtask

        task automatic pause_random();
                idle_cycles($unsigned($random(seed)) % 3);
        endtask

        task automatic bus_transfer(input logic we, input logic [2:0] addr,
                                    input logic [31:0] wdata, output logic [31:0] rdata);
                int waited;
                waited = 0;
                wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, addr: addr, wdata: wdata};
                do begin
                        @(posedge clk);
                        #2;
                        waited++;
                end while (!wb_rsp.ack && waited < 20);
                rdata = wb_rsp.rdata; // Valid while ack is high
                wb_req = '0;
                if (!wb_rsp.ack) begin
                        $display("Timed out waiting for ack at address %0d", addr);
                        test_errors++;
                end
        endtask

        task automatic write_word(input logic [2:0] addr, input logic [31:0] data);
                logic [31:0] ignored;
                pause_random();
                bus_transfer(1'b1, addr, data, ignored);
        endtask

        task automatic read_word(input logic [2:0] addr, output logic [31:0] data);
                pause_random();
                bus_transfer(1'b0, addr, 32'd0, data);
        endtask

        task automatic load_block(input logic [63:0] key, input logic [63:0] text);
                write_word(addr_key_hi, key[63:32]);
                write_word(addr_key_lo, key[31:0]);
                write_word(addr_text_hi, text[63:32]);
                write_word(addr_text_lo, text[31:0]);
        endtask

        // One idle cycle lets busy rise before anyone polls it
        task automatic start_core();
                write_word(addr_ctrl, 32'd1);
                idle_cycles(1);
        endtask

        task automatic wait_idle();
                logic [31:0] status;
                int polls;
                polls = 0;
                status = 32'd1;
                while (status[0] && polls < 40) begin
                        read_word(addr_ctrl, status);
                        polls++;
                end
                if (status[0]) begin
                        $display("Timed out waiting for busy to fall");
                        test_errors++;
                end
        endtask

        task automatic read_result(output logic [63:0] result);
                logic [31:0] hi;
                logic [31:0] lo;
                read_word(addr_res_hi, hi);
                read_word(addr_res_lo, lo);
                result = {hi, lo};
        endtask

        task automatic report_mismatch(input string name, input logic [63:0] expected,
                                       input logic [63:0] actual);
                $display("FAIL %s expected %h actual %h", name, expected, actual);
                test_errors++;
        endtask

        task automatic finish_test(input string name);
                if (test_errors == 0) begin
                        $display("PASS %s", name);
                        pass_count++;
                end else begin
                        $display("Test %s finished with %0d errors", name, test_errors);
                        fail_count++;
                end
                test_errors = 0;
        endtask

        function automatic int find_case(input string name);
                for (int i = 0; i < names.size(); i++)
                        if (names[i] == name)
                                return i;
                return -1;
        endfunction

        initial begin
                string tok;
                string rest;
                logic [63:0] k;
                logic [63:0] p;
                logic [63:0] c;
                logic [63:0] got;
                logic [31:0] word;
                logic [31:0] pattern [4];
                int fd;
                int n;
                int orig_idx;
                int new_idx;

                seed = 32'h7754;
                pass_count = 0;
                fail_count = 0;
                test_errors = 0;
                wb_req = '0;
                arst_n = 1'b0;

                fd = $fopen("verification/des_cases.txt", "r");
                if (fd == 0) begin
                        $display("Could not open the case file verification/des_cases.txt");
                        fail_count++;
                end else begin
                        while ($fscanf(fd, "%s", tok) == 1) begin
                                if (tok[0] == "#") begin
                                        n = $fgets(rest, fd); // Skip the rest of a comment line
                                end else if ($fscanf(fd, "%h %h %h", k, p, c) == 3) begin
                                        names.push_back(tok);
                                        keys.push_back(k);
                                        texts.push_back(p);
                                        ciphers.push_back(c);
                                end
                        end
                        $fclose(fd);
                end
                if (names.size() == 0) begin
                        $display("No cases were read from the case file");
                        fail_count++;
                end

                repeat (2) @(posedge clk);
                #2;
                arst_n = 1'b1;
                idle_cycles(1);

                // Unmapped address 7 must read as zero too
                for (int a = 0; a < 8; a++) begin
                        read_word(3'(a), word);
                        if (word !== 32'd0)
                                report_mismatch($sformatf("reset_addr_%0d", a), 64'd0, 64'(word));
                end
                finish_test("reset_values");

                for (int i = 0; i < names.size(); i++) begin
                        load_block(keys[i], texts[i]);
                        start_core();
                        wait_idle();
                        read_result(got);
                        if (got !== ciphers[i])
                                report_mismatch(names[i], ciphers[i], got);
                        finish_test(names[i]);
                end

                for (int a = 0; a < 4; a++) begin
                        pattern[a] = $random(seed);
                        write_word(3'(a), pattern[a]);
                end
                for (int a = 0; a < 4; a++) begin
                        read_word(3'(a), word);
                        if (word !== pattern[a])
                                report_mismatch($sformatf("readback_addr_%0d", a),
                                                64'(pattern[a]), 64'(word));
                end
                finish_test("register_readback");

                if (names.size() > 0) begin
                        load_block(keys[0], texts[0]);
                        start_core();
                        bus_transfer(1'b0, addr_ctrl, 32'd0, word);
                        if (word !== 32'd1)
                                report_mismatch("busy_after_start", 64'd1, 64'(word));
                        wait_idle();
                        read_result(got);
                        if (got !== ciphers[0])
                                report_mismatch("busy_run_result", ciphers[0], got);
                end
                finish_test("busy_status");

                orig_idx = find_case("now_is_t");
                new_idx = find_case("ones_text");
                if (orig_idx < 0 || new_idx < 0 || keys[orig_idx] !== keys[new_idx]) begin
                        $display("The case file lacks now_is_t and ones_text under one key");
                        test_errors++;
                end else begin
                        load_block(keys[orig_idx], texts[orig_idx]);
                        start_core();
                        write_word(addr_text_hi, texts[new_idx][63:32]); // Core is mid run
                        write_word(addr_text_lo, texts[new_idx][31:0]);
                        wait_idle();
                        read_result(got);
                        if (got !== ciphers[orig_idx])
                                report_mismatch("rewrite_running_block", ciphers[orig_idx], got);
                        start_core();
                        wait_idle();
                        read_result(got);
                        if (got !== ciphers[new_idx])
                                report_mismatch("rewrite_next_block", ciphers[new_idx], got);
                end
                finish_test("text_rewrite");

                $display("Tests passed %0d, tests failed %0d", pass_count, fail_count);
                if (fail_count == 0)
                        $display("All checks passed");
                else
                        $display("Checks failed");
                $finish;
        end

endmodule

// ==== verilog.f ====
source/des_pkg.sv
source/des_key_schedule.sv
source/des_feistel.sv
source/des_core.sv
source/des_wb_regs.sv
source/des_top.sv
verification/des_props.sv
verification/des_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the DES testbench with Verilator, runs it and scans the log for failures
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f verilog.f --top-module des_tb \
        -Mdir obj_dir -o des_sim > build.log 2>&1 &&
./obj_dir/des_sim > sim.log 2>&1 &&
! grep -q "Checks failed" sim.log &&
grep -q "All checks passed" sim.log &&
echo "Simulation finished without failures" ||
{ echo "Simulation failed, see build.log and sim.log"; exit 1; }

// ==== verification/des_cases.txt ====
# Each line holds a case name, the key, the plaintext and the expected ciphertext
# All values are 64-bit hex
standard 133457799BBCDFF1 0123456789ABCDEF 85E813540F0AB405
zero_out 0E329232EA6D0D73 8787878787878787 0000000000000000
all_zero 0000000000000000 0000000000000000 8CA64DE9C1B123A7
all_ones FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 7359B2163E4EDC58
now_is_t 0123456789ABCDEF 4E6F772069732074 3FA40E8A984D4815
ones_text 0123456789ABCDEF 1111111111111111 17668DFC7292532D
